//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_mmu
FILELIST  ?= mmu_top.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "no result in log"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- mmu_checker.sv
// Response checker for the MMU testbench.
// Watches both lookup ports and the Wishbone bus, compares each answer
// with the expected values of the current table row and counts reads.
// Raises done once every expected side has answered.
`timescale 1ns/1ps

module mmu_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  i_resp,
    input  logic [7:0]  i_perm,
    input  logic [63:0] i_padd,
    input  logic [7:0]  d_resp,
    input  logic [7:0]  d_perm,
    input  logic [63:0] d_padd,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic        wb_ack,
    input  logic        start,      // new group of requests
    input  logic        i_en,
    input  logic [7:0]  i_id,
    input  logic [7:0]  i_exp_perm,
    input  logic [63:0] i_exp_padd,
    input  logic        d_en,
    input  logic [7:0]  d_id,
    input  logic [7:0]  d_exp_perm,
    input  logic [63:0] d_exp_padd,
    input  int          exp_reads,  // PTE reads for the whole group
    output logic        done,
    output int          errors
);
    int   reads;
    logic i_seen;
    logic d_seen;

    task automatic compare_resp(input string side, input logic [7:0] id,
                                input logic [7:0] perm, input logic [63:0] padd,
                                input logic en, input logic seen,
                                input logic [7:0] exp_id, input logic [7:0] exp_perm,
                                input logic [63:0] exp_padd);
        if (!en || seen) begin
            errors = errors + 1;
            $display("[ERROR] %0t: unexpected %s response, id %h", $time, side, id);
        end else if (id != exp_id) begin
            errors = errors + 1;
            $display("[ERROR] %0t: %s_resp %h, expected %h", $time, side, id, exp_id);
        end else begin
            if (perm != exp_perm) begin
                errors = errors + 1;
                $display("[ERROR] %0t: %s_perm %h, expected %h",
                         $time, side, perm, exp_perm);
            end
            // a fault carries no address
            if (exp_perm != 8'h00 && padd != exp_padd) begin
                errors = errors + 1;
                $display("[ERROR] %0t: %s_padd %h, expected %h",
                         $time, side, padd, exp_padd);
            end
        end
    endtask

    initial errors = 0;

    always @(posedge clk) begin
        if (rst) begin
            reads  <= 0;
            i_seen <= 1'b0;
            d_seen <= 1'b0;
            done   <= 1'b0;
        end else if (start) begin
            reads  <= 0;
            i_seen <= 1'b0;
            d_seen <= 1'b0;
            done   <= 1'b0;
        end else begin
            if (wb_cyc && wb_stb && wb_ack) begin
                reads <= reads + 1;  // one PTE read finished
                if (wb_we) begin
                    errors = errors + 1;
                    $display("[ERROR] %0t: walker issued a write", $time);
                end
            end
            if (|i_resp) begin
                compare_resp("i", i_resp, i_perm, i_padd, i_en, i_seen,
                             i_id, i_exp_perm, i_exp_padd);
                i_seen <= 1'b1;
            end
            if (|d_resp) begin
                compare_resp("d", d_resp, d_perm, d_padd, d_en, d_seen,
                             d_id, d_exp_perm, d_exp_padd);
                d_seen <= 1'b1;
            end
            if (!done && (i_en || d_en) && (i_seen || !i_en) && (d_seen || !d_en)) begin
                if (reads != exp_reads) begin
                    errors = errors + 1;
                    $display("[ERROR] %0t: %0d Wishbone reads, expected %0d",
                             $time, reads, exp_reads);
                end
                done <= 1'b1;
            end
        end
    end

endmodule

//--- mmu_consts.svh
// Geometry and width constants for the MMU.
// Include wherever TLB size, ID width or walk depth is needed.
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// sets per TLB, power of two
`define TLB_SETS 16

// ways per TLB, power of two
`define TLB_WAYS 4

// request ID width, zero means idle
`define ID_W 8

// Sv39 walk depth
`define PT_LEVELS 3

`endif

//--- mmu_pkg.sv
// Shared types for the Sv39 MMU.
// Holds the page-table entry word and the SATP mode encodings.
// Modules take it with a wildcard import inside their body.
package mmu_pkg;

    // mode field in satp[63:60]
    localparam logic [3:0] satp_bare = 4'd0;
    localparam logic [3:0] satp_sv39 = 4'd8;

    // bit positions inside the PTE flag byte
    localparam int pte_v = 0;
    localparam int pte_r = 1;
    localparam int pte_w = 2;
    localparam int pte_x = 3;

    // One PTE word seen two ways. A walker reads it as a pointer to the
    // next table until R or X shows it to be a leaf.
    typedef union packed {
        struct packed {
            logic [9:0]  rsvd;  // must be zero
            logic [43:0] ppn;   // next-level table
            logic [1:0]  rsw;   // left to software
            logic [7:0]  flags; // D A G U X W R V
        } ptr;
        struct packed {
            logic [9:0]  rsvd;
            logic [25:0] ppn2;  // 1 GiB frame
            logic [8:0]  ppn1;  // 2 MiB frame
            logic [8:0]  ppn0;  // 4 KiB frame
            logic [1:0]  rsw;
            logic [7:0]  flags; // handed back as permission
        } leaf;
    } pte_u;

endpackage

//--- mmu_top.f
+incdir+.
mmu_pkg.sv
tlb.sv
ptw.sv
mmu_top.sv
mmu_checker.sv
tb_mmu.sv

//--- mmu_top.sv
// Top level of the Sv39 MMU with an instruction TLB, a data TLB and
// the page-table walker they share.
// Lookups enter on the i_ and d_ ports and page-table reads leave on
// the Wishbone master port.
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic [`ID_W-1:0] i_rqst, // instruction fetch lookups
    input  logic [63:0]      i_vadd,
    input  logic [63:0]      i_satp,
    output logic [`ID_W-1:0] i_resp,
    output logic [7:0]       i_perm,
    output logic [63:0]      i_padd,
    input  logic [`ID_W-1:0] d_rqst, // load/store lookups
    input  logic [63:0]      d_vadd,
    input  logic [63:0]      d_satp,
    output logic [`ID_W-1:0] d_resp,
    output logic [7:0]       d_perm,
    output logic [63:0]      d_padd,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [63:0]      wb_adr,
    input  logic [63:0]      wb_dat_i,
    input  logic             wb_ack
);
    // itlb to walker
    logic [`ID_W-1:0] iw_rqst;
    logic [63:0]      iw_vadd;
    logic [63:0]      iw_satp;
    logic [`ID_W-1:0] iw_resp;
    logic [7:0]       iw_perm;
    logic [63:0]      iw_padd;

    // dtlb to walker
    logic [`ID_W-1:0] dw_rqst;
    logic [63:0]      dw_vadd;
    logic [63:0]      dw_satp;
    logic [`ID_W-1:0] dw_resp;
    logic [7:0]       dw_perm;
    logic [63:0]      dw_padd;

    tlb #(.sets(`TLB_SETS), .ways(`TLB_WAYS)) itlb_i (
        .clk    (clk),
        .rst    (rst),
        .s_rqst (i_rqst),
        .s_vadd (i_vadd),
        .s_satp (i_satp),
        .s_resp (i_resp),
        .s_perm (i_perm),
        .s_padd (i_padd),
        .m_rqst (iw_rqst),
        .m_vadd (iw_vadd),
        .m_satp (iw_satp),
        .m_resp (iw_resp),
        .m_perm (iw_perm),
        .m_padd (iw_padd)
    );

    tlb #(.sets(`TLB_SETS), .ways(`TLB_WAYS)) dtlb_i (
        .clk    (clk),
        .rst    (rst),
        .s_rqst (d_rqst),
        .s_vadd (d_vadd),
        .s_satp (d_satp),
        .s_resp (d_resp),
        .s_perm (d_perm),
        .s_padd (d_padd),
        .m_rqst (dw_rqst),
        .m_vadd (dw_vadd),
        .m_satp (dw_satp),
        .m_resp (dw_resp),
        .m_perm (dw_perm),
        .m_padd (dw_padd)
    );

    ptw ptw_i (
        .clk      (clk),
        .rst      (rst),
        .i_rqst   (iw_rqst),
        .i_vadd   (iw_vadd),
        .i_satp   (iw_satp),
        .i_resp   (iw_resp),
        .i_perm   (iw_perm),
        .i_padd   (iw_padd),
        .d_rqst   (dw_rqst),
        .d_vadd   (dw_vadd),
        .d_satp   (dw_satp),
        .d_resp   (dw_resp),
        .d_perm   (dw_perm),
        .d_padd   (dw_padd),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

endmodule

//--- ptw.sv
// Sv39 page-table walker shared by the instruction and data TLBs.
// Serves one miss at a time with the instruction side first, reading
// one PTE per level over a Wishbone classic master port. The result is
// returned for one cycle on the granted side; perm zero marks a fault.
`timescale 1ns/1ps
`include "mmu_consts.svh"

module ptw (
    input  logic             clk,
    input  logic             rst,
    input  logic [`ID_W-1:0] i_rqst,
    input  logic [63:0]      i_vadd,
    input  logic [63:0]      i_satp,
    output logic [`ID_W-1:0] i_resp,
    output logic [7:0]       i_perm,
    output logic [63:0]      i_padd,
    input  logic [`ID_W-1:0] d_rqst,
    input  logic [63:0]      d_vadd,
    input  logic [63:0]      d_satp,
    output logic [`ID_W-1:0] d_resp,
    output logic [7:0]       d_perm,
    output logic [63:0]      d_padd,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [63:0]      wb_adr,
    input  logic [63:0]      wb_dat_i,
    input  logic             wb_ack
);
    import mmu_pkg::*;

    localparam int lvl_w = $clog2(`PT_LEVELS);
    localparam logic [lvl_w-1:0] lvl_top = lvl_w'(`PT_LEVELS - 1);
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_read = 2'd1; // bus held until ack
    localparam logic [1:0] st_gap  = 2'd2; // bus released between levels

    logic [1:0]       state;
    logic             sel_d;     // walk belongs to the data side
    logic [lvl_w-1:0] lvl;
    logic [`ID_W-1:0] w_id;
    logic [63:0]      w_vadd;
    logic [7:0]       r_perm;
    logic [63:0]      r_padd;

    logic             g_any;
    logic             g_sel;
    logic [`ID_W-1:0] g_id;
    logic [63:0]      g_vadd;
    logic [63:0]      g_satp;

    pte_u             pte;
    logic             pte_fault;
    logic             pte_leaf;
    logic             mode_flt;
    logic             walk_end;
    logic             done;
    logic             rsp_sel;
    logic [`ID_W-1:0] rsp_id;
    logic [7:0]       rsp_perm;
    logic [63:0]      leaf_padd;

    function automatic logic [8:0] vpn_slice(input logic [63:0] va,
                                             input logic [lvl_w-1:0] l);
        vpn_slice = va[12 + 9 * l +: 9];
    endfunction

    function automatic logic [63:0] pte_adr(input logic [43:0] ppn,
                                            input logic [8:0] vpn);
        pte_adr = {8'h00, ppn, vpn, 3'b000}; // 8-byte entries
    endfunction

    always_comb begin
        g_any  = |i_rqst || |d_rqst;
        g_sel  = !(|i_rqst);  // instruction side first
        g_id   = g_sel ? d_rqst : i_rqst;
        g_vadd = g_sel ? d_vadd : i_vadd;
        g_satp = g_sel ? d_satp : i_satp;
    end

    always_comb begin
        pte       = wb_dat_i;
        pte_fault = !pte.ptr.flags[pte_v]
                    || (pte.ptr.flags[pte_w] && !pte.ptr.flags[pte_r]);
        pte_leaf  = pte.ptr.flags[pte_r] || pte.ptr.flags[pte_x];
        // superpage leaves take the low PPN parts from the VPN
        leaf_padd = {8'h00, pte.leaf.ppn2,
                     (lvl >= 2) ? w_vadd[29:21] : pte.leaf.ppn1,
                     (lvl >= 1) ? w_vadd[20:12] : pte.leaf.ppn0,
                     12'h000};
    end

    always_comb begin
        mode_flt = (state == st_idle) && g_any && (g_satp[63:60] != satp_sv39);
        walk_end = (state == st_read) && wb_ack
                   && (pte_fault || pte_leaf || lvl == '0);
        done     = mode_flt || walk_end;
        rsp_sel  = (state == st_idle) ? g_sel : sel_d;
        rsp_id   = (state == st_idle) ? g_id : w_id;
        rsp_perm = (mode_flt || pte_fault || !pte_leaf) ? 8'h00 : pte.leaf.flags;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            sel_d  <= 1'b0;
            lvl    <= lvl_top;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            i_resp <= '0;
            d_resp <= '0;
        end else begin
            i_resp <= (done && !rsp_sel) ? rsp_id : '0;
            d_resp <= (done && rsp_sel) ? rsp_id : '0;
            case (state)
                st_idle: begin
                    if (g_any && !mode_flt) begin
                        state  <= st_read;
                        sel_d  <= g_sel;
                        lvl    <= lvl_top;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                st_read: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state  <= walk_end ? st_idle : st_gap;
                        if (!walk_end) begin
                            lvl <= lvl - 1'b1;
                        end
                    end
                end
                st_gap: begin
                    state  <= st_read;
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            r_perm <= rsp_perm;
            r_padd <= (rsp_perm == 8'h00) ? '0 : leaf_padd;
        end
        if (state == st_idle && g_any) begin
            w_id   <= g_id;
            w_vadd <= g_vadd;
            wb_adr <= pte_adr(g_satp[43:0], vpn_slice(g_vadd, lvl_top)); // root table
        end else if (state == st_read && wb_ack && !walk_end) begin
            wb_adr <= pte_adr(pte.ptr.ppn, vpn_slice(w_vadd, lvl - 1'b1));
        end
    end

    assign i_perm = r_perm;
    assign i_padd = r_padd;
    assign d_perm = r_perm;
    assign d_padd = r_padd;
    assign wb_we  = 1'b0;  // reads only

    // classic cycle ends right after its ack
    a_ack_drop: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && wb_ack) |=> !wb_cyc && !wb_stb);

    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> $stable(wb_adr));

    // each answer goes back to the side that asked for it
    a_i_side: assert property (@(posedge clk) disable iff (rst)
        |i_resp |-> i_resp == $past(i_rqst));

    a_d_side: assert property (@(posedge clk) disable iff (rst)
        |d_resp |-> d_resp == $past(d_rqst));

endmodule

//--- tb_mmu.sv
// Testbench for the Sv39 MMU top level.
// Builds page tables in a Wishbone memory model with random wait states,
// then applies a table of lookups and expected results row by row.
// Rows marked as paired go out on both ports in the same cycle.
`timescale 1ns/1ps
`include "mmu_consts.svh"

module tb_mmu;
    import mmu_pkg::*;

    logic             clk;
    logic             rst;
    logic [`ID_W-1:0] i_rqst;
    logic [63:0]      i_vadd;
    logic [63:0]      i_satp;
    logic [`ID_W-1:0] i_resp;
    logic [7:0]       i_perm;
    logic [63:0]      i_padd;
    logic [`ID_W-1:0] d_rqst;
    logic [63:0]      d_vadd;
    logic [63:0]      d_satp;
    logic [`ID_W-1:0] d_resp;
    logic [7:0]       d_perm;
    logic [63:0]      d_padd;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [63:0]      wb_adr;
    logic [63:0]      wb_dat;
    logic             wb_ack;

    logic             start;
    logic             i_en;
    logic [7:0]       i_id;
    logic [7:0]       i_exp_perm;
    logic [63:0]      i_exp_padd;
    logic             d_en;
    logic [7:0]       d_id;
    logic [7:0]       d_exp_perm;
    logic [63:0]      d_exp_padd;
    int               exp_reads;
    logic             done;
    int               errors;

    logic [63:0] mem [logic [63:0]];  // PTE words by byte address
    logic        r_port [32];         // 0 instruction, 1 data
    logic        r_pair [32];         // goes out with the next row
    logic [63:0] r_vadd [32];
    logic [63:0] r_satp [32];
    logic [7:0]  r_perm [32];
    logic [63:0] r_padd [32];
    int          r_reads [32];
    int          n_rows;
    int          cycles;
    logic        busy;
    int unsigned wait_left;

    localparam logic [63:0] satp_a = {satp_sv39, 16'h0001, 44'h100};
    localparam logic [63:0] satp_b = {satp_sv39, 16'h0002, 44'h200};

    mmu_top dut_i (.*, .wb_dat_i(wb_dat));

    mmu_checker chk_i (.*);

    // PTE at index idx of the table in page tbl
    function automatic logic [63:0] slot(input logic [43:0] tbl, input logic [8:0] idx);
        slot = {8'h00, tbl, 12'h000} + {52'h0, idx, 3'b000};
    endfunction

    function automatic logic [63:0] mk_ptr(input logic [43:0] ppn);
        pte_u p;
        p = '0;
        p.ptr.ppn   = ppn;
        p.ptr.flags = 8'h01;  // valid, no R/W/X
        mk_ptr = p;
    endfunction

    function automatic logic [63:0] mk_leaf(input logic [43:0] ppn, input logic [7:0] flags);
        pte_u p;
        p = '0;
        p.leaf.ppn2  = ppn[43:18];
        p.leaf.ppn1  = ppn[17:9];
        p.leaf.ppn0  = ppn[8:0];
        p.leaf.flags = flags;
        mk_leaf = p;
    endfunction

    function automatic logic [63:0] pa4k(input logic [43:0] ppn, input logic [63:0] va);
        pa4k = {8'h00, ppn, va[11:0]};
    endfunction

    function automatic logic [63:0] read_pte(input logic [63:0] a);
        read_pte = mem.exists(a) ? mem[a] : 64'h0;  // missing entry reads as invalid
    endfunction

    task automatic build_memory();
        logic [8:0] v;
        mem[slot(44'h100, 9'd0)] = mk_ptr(44'h101);
        mem[slot(44'h100, 9'd2)] = mk_leaf({26'h9, 18'h0}, 8'hcb);        // 1 GiB
        mem[slot(44'h101, 9'd0)] = mk_ptr(44'h102);
        mem[slot(44'h101, 9'd5)] = mk_leaf({26'h3, 9'h77, 9'h0}, 8'hc7);  // 2 MiB
        for (int k = 0; k < 5; k++) begin
            v = 9'h003 + 9'(k * 16);  // all in set 3
            mem[slot(44'h102, v)] = mk_leaf(44'h5000 + 44'(v), 8'hcf);
        end
        mem[slot(44'h102, 9'd8)] = mk_leaf(44'h5008, 8'hcb);
        mem[slot(44'h102, 9'd7)] = mk_ptr(44'h300);  // pointer at last level
        mem[slot(44'h200, 9'd0)] = mk_ptr(44'h201);
        mem[slot(44'h201, 9'd0)] = mk_ptr(44'h202);
        mem[slot(44'h202, 9'd3)] = mk_leaf(44'h6003, 8'hc3);
        mem[slot(44'h202, 9'd9)] = mk_leaf(44'h6009, 8'hc7);
    endtask

    task automatic add_row(input logic port, input logic pair, input logic [63:0] va,
                           input logic [63:0] satp, input logic [7:0] perm,
                           input logic [63:0] pa, input int reads);
        r_port[n_rows]  = port;
        r_pair[n_rows]  = pair;
        r_vadd[n_rows]  = va;
        r_satp[n_rows]  = satp;
        r_perm[n_rows]  = perm;
        r_padd[n_rows]  = pa;
        r_reads[n_rows] = reads;
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        logic [63:0] va_m;
        logic [63:0] va_g;
        va_m = 64'hba5321;  // vpn1 5, vpn0 1a5
        va_g = 64'h8895_5777;  // vpn2 2, vpn1 44, vpn0 155
        n_rows = 0;
        add_row(1'b1, 1'b0, 64'h1234_5678_9abc_def0, 64'h0, 8'hff,
                64'h1234_5678_9abc_def0, 0);
        add_row(1'b0, 1'b0, 64'h40_0000_1008, 64'h0, 8'hff, 64'h40_0000_1008, 0);
        add_row(1'b0, 1'b0, 64'h3abc, satp_a, 8'hcf, pa4k(44'h5003, 64'h3abc), 3);
        add_row(1'b0, 1'b0, 64'h3123, satp_a, 8'hcf, pa4k(44'h5003, 64'h3123), 0);
        add_row(1'b1, 1'b0, 64'h3abc, satp_a, 8'hcf, pa4k(44'h5003, 64'h3abc), 3);
        add_row(1'b0, 1'b0, 64'h13040, satp_a, 8'hcf, pa4k(44'h5013, 64'h13040), 3);
        add_row(1'b0, 1'b0, 64'h23040, satp_a, 8'hcf, pa4k(44'h5023, 64'h23040), 3);
        add_row(1'b0, 1'b0, 64'h33040, satp_a, 8'hcf, pa4k(44'h5033, 64'h33040), 3);
        add_row(1'b0, 1'b0, 64'h3010, satp_a, 8'hcf, pa4k(44'h5003, 64'h3010), 0);
        // fifth page in set 3 pushes out the oldest
        add_row(1'b0, 1'b0, 64'h43040, satp_a, 8'hcf, pa4k(44'h5043, 64'h43040), 3);
        add_row(1'b0, 1'b0, 64'h3abc, satp_a, 8'hcf, pa4k(44'h5003, 64'h3abc), 3);
        add_row(1'b0, 1'b0, 64'h13040, satp_a, 8'hcf, pa4k(44'h5013, 64'h13040), 3);
        add_row(1'b0, 1'b0, 64'h33040, satp_a, 8'hcf, pa4k(44'h5033, 64'h33040), 0);
        add_row(1'b0, 1'b0, 64'h4000_0000, satp_a, 8'h00, 64'h0, 1);  // invalid root entry
        add_row(1'b1, 1'b0, 64'h7000, satp_a, 8'h00, 64'h0, 3);
        add_row(1'b1, 1'b0, va_m, satp_a, 8'hc7,
                {8'h00, 26'h3, 9'h77, va_m[20:12], va_m[11:0]}, 2);
        add_row(1'b0, 1'b0, va_g, satp_a, 8'hcb, {8'h00, 26'h9, va_g[29:0]}, 1);
        add_row(1'b1, 1'b0, 64'h3abc, satp_b, 8'hc3, pa4k(44'h6003, 64'h3abc), 3);
        add_row(1'b0, 1'b1, 64'h8000, satp_a, 8'hcb, pa4k(44'h5008, 64'h8000), 3);
        add_row(1'b1, 1'b0, 64'h9010, satp_b, 8'hc7, pa4k(44'h6009, 64'h9010), 3);
        add_row(1'b0, 1'b1, 64'h8004, satp_a, 8'hcb, pa4k(44'h5008, 64'h8004), 0);
        add_row(1'b1, 1'b0, 64'h9018, satp_b, 8'hc7, pa4k(44'h6009, 64'h9018), 0);
    endtask

    // puts one row on its port and loads the checker
    task automatic issue_row(input int r);
        if (r_port[r]) begin
            d_rqst     <= 8'(r + 1);
            d_vadd     <= r_vadd[r];
            d_satp     <= r_satp[r];
            d_en       <= 1'b1;
            d_id       <= 8'(r + 1);
            d_exp_perm <= r_perm[r];
            d_exp_padd <= r_padd[r];
        end else begin
            i_rqst     <= 8'(r + 1);
            i_vadd     <= r_vadd[r];
            i_satp     <= r_satp[r];
            i_en       <= 1'b1;
            i_id       <= 8'(r + 1);
            i_exp_perm <= r_perm[r];
            i_exp_padd <= r_padd[r];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Wishbone slave with 0 to 3 wait states
    always @(posedge clk) begin : wb_slave
        int unsigned delay;
        if (rst) begin
            wb_ack <= 1'b0;
            busy   <= 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                delay = $urandom % 4;
                if (delay == 0) begin
                    wb_ack <= 1'b1;
                    wb_dat <= read_pte(wb_adr);
                end else begin
                    busy      <= 1'b1;
                    wait_left <= delay - 1;
                end
            end else if (wait_left == 0) begin
                wb_ack <= 1'b1;
                wb_dat <= read_pte(wb_adr);
                busy   <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles >= n_rows * 40) begin
                $display("timeout: responses stopped after %0d cycles", cycles);
                $display("errors: %0d", errors);
                $display("STATUS: FAIL");
                $finish;
            end
        end
    end

    initial begin : main
        int r;
        void'($urandom(13750));
        rst = 1'b1;
        start = 1'b0;
        i_rqst = '0;
        i_vadd = '0;
        i_satp = '0;
        d_rqst = '0;
        d_vadd = '0;
        d_satp = '0;
        wb_dat = '0;
        wb_ack = 1'b0;
        i_en = 1'b0;
        i_id = '0;
        i_exp_perm = '0;
        i_exp_padd = '0;
        d_en = 1'b0;
        d_id = '0;
        d_exp_perm = '0;
        d_exp_padd = '0;
        exp_reads = 0;
        build_memory();
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        r = 0;
        while (r < n_rows) begin
            @(posedge clk);
            i_en  <= 1'b0;
            d_en  <= 1'b0;
            start <= 1'b1;
            issue_row(r);
            exp_reads <= r_reads[r];
            if (r_pair[r]) begin
                issue_row(r + 1);
                exp_reads <= r_reads[r] + r_reads[r + 1];
                r = r + 1;
            end
            r = r + 1;
            @(posedge clk);
            start  <= 1'b0;
            i_rqst <= '0;  // one cycle per request
            d_rqst <= '0;
            do begin
                @(posedge clk);
            end while (!done);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tlb.sv
// Set-associative TLB for Sv39 with a single request channel.
// A lookup is answered one cycle after it is presented. A miss waits in
// one MSHR, goes to the walker, and is replayed once the refill lands.
// Ways are replaced in FIFO order per set; bare mode passes through.
`timescale 1ns/1ps
`include "mmu_consts.svh"

module tlb #(
    parameter int sets = `TLB_SETS, // power of two
    parameter int ways = `TLB_WAYS  // power of two
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [`ID_W-1:0] s_rqst, // zero when idle
    input  logic [63:0]      s_vadd,
    input  logic [63:0]      s_satp,
    output logic [`ID_W-1:0] s_resp,
    output logic [7:0]       s_perm, // zero on page fault
    output logic [63:0]      s_padd,
    output logic [`ID_W-1:0] m_rqst, // held until m_resp
    output logic [63:0]      m_vadd,
    output logic [63:0]      m_satp,
    input  logic [`ID_W-1:0] m_resp,
    input  logic [7:0]       m_perm,
    input  logic [63:0]      m_padd
);
    import mmu_pkg::*;

    localparam int idx_w = $clog2(sets);
    localparam int way_w = $clog2(ways);
    localparam int tag_w = 68; // asid and vpn
    localparam int dat_w = 52; // ppn

    logic [ways-1:0][tag_w-1:0] tlb_tag [sets];
    logic [ways-1:0][dat_w-1:0] tlb_dat [sets];
    logic [ways-1:0][7:0]       tlb_prm [sets];
    logic [sets-1:0][ways-1:0]  tlb_vld;
    logic [sets-1:0][way_w-1:0] tlb_ptr;  // next victim per set

    logic [`ID_W-1:0]           b_rqst;
    logic [63:0]                b_vadd;
    logic [63:0]                b_satp;
    logic [ways-1:0][tag_w-1:0] set_tag;
    logic [ways-1:0][dat_w-1:0] set_dat;
    logic [ways-1:0][7:0]       set_prm;
    logic [ways-1:0]            set_vld;
    logic [way_w-1:0]           set_ptr;

    logic [`ID_W-1:0]           mis_req;  // nonzero while a miss is out
    logic [63:0]                mis_add;
    logic [63:0]                mis_csr;
    logic [ways-1:0][tag_w-1:0] mis_tag;
    logic [ways-1:0][dat_w-1:0] mis_dat;
    logic [ways-1:0][7:0]       mis_prm;
    logic [ways-1:0]            mis_vld;
    logic [way_w-1:0]           mis_ptr;

    logic [ways-1:0][tag_w-1:0] fil_tag;
    logic [ways-1:0][dat_w-1:0] fil_dat;
    logic [ways-1:0][7:0]       fil_prm;
    logic [ways-1:0]            fil_vld;

    logic [idx_w-1:0]           s_idx;
    logic [idx_w-1:0]           m_idx;
    logic [tag_w-1:0]           lk_tag;
    logic                       bare;
    logic                       hit_any;
    logic [way_w-1:0]           hit_way;
    logic                       miss_new;
    logic                       refill;
    logic                       fault;

    assign s_idx  = s_vadd[12 +: idx_w];
    assign m_idx  = mis_add[12 +: idx_w];
    assign lk_tag = {b_satp[59:44], b_vadd[63:12]};
    assign bare   = b_satp[63:60] == satp_bare;
    assign refill = |m_resp && |m_perm;
    assign fault  = |m_resp && !(|m_perm);

    // victim way takes the walker result
    always_comb begin
        fil_tag = mis_tag;
        fil_dat = mis_dat;
        fil_prm = mis_prm;
        fil_vld = mis_vld;
        fil_tag[mis_ptr] = {mis_csr[59:44], mis_add[63:12]};
        fil_dat[mis_ptr] = m_padd[63:12];
        fil_prm[mis_ptr] = m_perm;
        fil_vld[mis_ptr] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            tlb_tag[m_idx] <= fil_tag;
            tlb_dat[m_idx] <= fil_dat;
            tlb_prm[m_idx] <= fil_prm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tlb_vld <= '0;
            tlb_ptr <= '0;
        end else if (refill) begin
            tlb_vld[m_idx] <= fil_vld;
            tlb_ptr[m_idx] <= mis_ptr + 1'b1;
        end
    end

    // request buffer, replaced by the missed request on refill
    always_ff @(posedge clk) begin
        if (rst) begin
            b_rqst  <= '0;
            set_vld <= '0;
        end else if (refill) begin
            b_rqst  <= mis_req;
            set_vld <= fil_vld;
        end else begin
            b_rqst  <= s_rqst;
            set_vld <= tlb_vld[s_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            b_vadd  <= mis_add;
            b_satp  <= mis_csr;
            set_tag <= fil_tag;
            set_dat <= fil_dat;
            set_prm <= fil_prm;
            set_ptr <= mis_ptr + 1'b1;
        end else begin
            b_vadd  <= s_vadd;
            b_satp  <= s_satp;
            set_tag <= tlb_tag[s_idx];
            set_dat <= tlb_dat[s_idx];
            set_prm <= tlb_prm[s_idx];
            set_ptr <= tlb_ptr[s_idx];
        end
    end

    // lowest matching way wins
    always_comb begin
        hit_any = bare;
        hit_way = '0;
        for (int j = ways - 1; j >= 0; j--) begin
            if (set_vld[j] && set_tag[j] == lk_tag) begin
                hit_any = 1'b1;
                hit_way = way_w'(j);
            end
        end
    end

    assign miss_new = |b_rqst && !hit_any && !(|mis_req);

    always_ff @(posedge clk) begin
        if (rst) begin
            mis_req <= '0;
        end else if (|m_resp) begin
            mis_req <= '0;
        end else if (miss_new) begin
            mis_req <= b_rqst;
        end
    end

    always_ff @(posedge clk) begin
        if (miss_new) begin
            mis_add <= b_vadd;
            mis_csr <= b_satp;
            mis_tag <= set_tag;
            mis_dat <= set_dat;
            mis_prm <= set_prm;
            mis_vld <= set_vld;
            mis_ptr <= set_ptr;
        end
    end

    always_comb begin
        s_resp = hit_any ? b_rqst : '0;
        s_perm = set_prm[hit_way];
        s_padd = {set_dat[hit_way], b_vadd[11:0]};
        if (bare) begin
            s_perm = 8'hff;
            s_padd = b_vadd;
        end
        if (fault) begin  // walker found no mapping
            s_resp = mis_req;
            s_perm = 8'h00;
            s_padd = '0;
        end
    end

    assign m_rqst = |m_resp ? '0 : mis_req;
    assign m_vadd = mis_add;
    assign m_satp = mis_csr;

    // answer carries an ID that came in on the port or waits in the MSHR
    a_resp_id: assert property (@(posedge clk) disable iff (rst)
        |s_resp |-> (s_resp == $past(s_rqst)) || (s_resp == $past(mis_req))
                    || (s_resp == mis_req));

    a_mrqst_hold: assert property (@(posedge clk) disable iff (rst)
        (|m_rqst && !(|m_resp)) |=> (m_rqst == $past(m_rqst)) || |m_resp);

endmodule
